//--- vlog.f
+incdir+design
+incdir+verif
design/isa_pkg.sv
design/pipe_pkg.sv
design/regfile_if.sv
design/reg_file.sv
design/bypass_unit.sv
design/reg_gen.sv
design/id_stage.sv
verif/tb_id_stage.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_id_stage -o sim_id_stage

# the simulator exits nonzero on $fatal, the search below decides the result
out=$(./obj_dir/sim_id_stage 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'all tests passed'; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

//--- verif/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// expected outputs of one decoded instruction
typedef struct packed {
  logic [`DATA_W-1:0] op1;
  logic               p1;
  logic [`DATA_W-1:0] op2;
  logic               p2;
  logic               den;
  logic [`REG_AW-1:0] dad;
} exp_t;

typedef enum logic [1:0] {EXT_NONE, EXT_ZERO, EXT_HIGH, EXT_SIGN} ext_t;

// mirror of the register array, written from wb
logic [`DATA_W-1:0] shadow [0:`NUM_REGS-1];

// youngest producer wins, then same-cycle wb, then the stored value
function automatic logic [`DATA_W-1:0] forwarded_value(input logic [`REG_AW-1:0] a);
  if (a == '0) return '0;
  if (ex_wen && ex_waddr == a) return ex_wdata;
  if (mem_wen && mem_waddr == a) return mem_wdata;
  if (wb_en && wb_addr == a) return wb_data;
  return shadow[a];
endfunction

function automatic logic load_in_ex(input logic [`REG_AW-1:0] a);
  return (a != '0) && ex_wen && (ex_waddr == a) && ex_is_load;
endfunction

function automatic exp_t decode_expect(input logic [`DATA_W-1:0] w,
                                       input logic [`DATA_W-1:0] p,
                                       input logic cp0);
  exp_t             e;
  logic [5:0]       op;
  logic [4:0]       rs;
  logic [4:0]       rt;
  logic [4:0]       a1;
  logic             r1;
  logic             r2;
  logic             link;
  ext_t             ext;
  op   = w[31:26];
  rs   = w[25:21];
  rt   = w[20:16];
  e    = '0;
  r1   = 1'b0;
  r2   = 1'b0;
  link = 1'b0;
  a1   = rs;
  ext  = EXT_NONE;
  if (op inside {`OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU,
                 `OP_LB, `OP_LH, `OP_LW, `OP_LBU, `OP_LHU}) begin
    r1  = 1'b1;
    ext = EXT_SIGN;
  end else if (op inside {`OP_ANDI, `OP_ORI, `OP_XORI}) begin
    r1  = 1'b1;
    ext = EXT_ZERO;
  end else if (op == `OP_LUI) begin
    ext = EXT_HIGH;
  end else if (op inside {`OP_SB, `OP_SH, `OP_SW}) begin
    r1  = 1'b1;
    r2  = 1'b1;
    ext = EXT_SIGN;
  end else if (op inside {`OP_BEQ, `OP_BNE, `OP_BLEZ, `OP_BGTZ,
                          `OP_SPECIAL, `OP_SPECIAL2}) begin
    r1   = 1'b1;
    r2   = 1'b1;
    link = (op == `OP_SPECIAL) && (w[5:0] == `FUNCT_JALR);
  end else if (op == `OP_JAL) begin
    link = 1'b1;
  end else if (op == `OP_REGIMM) begin
    r1   = rt inside {`REGIMM_BLTZ, `REGIMM_BGEZ, `REGIMM_BLTZAL, `REGIMM_BGEZAL};
    link = rt inside {`REGIMM_BLTZAL, `REGIMM_BGEZAL};
  end else if (op == `OP_CP0) begin
    r1 = 1'b1;
    a1 = rt;
  end
  // destination
  if (ext != EXT_NONE && !r2) begin
    e.den = 1'b1;
    e.dad = rt;
  end else if (op == `OP_SPECIAL || op == `OP_SPECIAL2) begin
    e.den = 1'b1;
    e.dad = w[15:11];
  end else if (link) begin
    e.den = 1'b1;
    e.dad = `LINK_REG;
  end else if (op == `OP_CP0 && rs == `CP0_MFC0 && cp0) begin
    e.den = 1'b1;
    e.dad = rt;
  end
  if (link) begin
    e.op1 = p + 32'd8;
  end else if (r1) begin
    e.op1 = forwarded_value(a1);
    e.p1  = load_in_ex(a1);
  end
  case (ext)
    EXT_ZERO: e.op2 = {16'd0, w[15:0]};
    EXT_HIGH: e.op2 = {w[15:0], 16'd0};
    EXT_SIGN: e.op2 = {{16{w[15]}}, w[15:0]};
    default: begin
      if (r2) begin
        e.op2 = forwarded_value(rt);
        e.p2  = load_in_ex(rt);
      end
    end
  endcase
  return e;
endfunction

`endif

//--- verif/tb_id_stage.sv
`timescale 1ns/1ps
`include "mips_consts.svh"

module tb_id_stage;

  localparam int N_INST      = 3000;
  localparam int DRAIN_LIMIT = 16;

  logic               clk;
  logic               rst;
  logic               inst_valid;
  logic [`DATA_W-1:0] inst;
  logic [`DATA_W-1:0] pc;
  logic               cp0_usable;
  logic               wb_en;
  logic [`REG_AW-1:0] wb_addr;
  logic [`DATA_W-1:0] wb_data;
  logic               ex_wen;
  logic [`REG_AW-1:0] ex_waddr;
  logic [`DATA_W-1:0] ex_wdata;
  logic               ex_is_load;
  logic               mem_wen;
  logic [`REG_AW-1:0] mem_waddr;
  logic [`DATA_W-1:0] mem_wdata;
  logic               out_valid;
  logic [`DATA_W-1:0] op1_data;
  logic               op1_pending;
  logic [`DATA_W-1:0] op2_data;
  logic               op2_pending;
  logic               dst_en;
  logic [`REG_AW-1:0] dst_addr;

`include "tb_model.svh"

  integer             seed;
  logic [5:0]         op_tbl [0:25];
  // values applied at the next drive point
  logic               nx_inst_valid;
  logic [`DATA_W-1:0] nx_inst;
  logic [`DATA_W-1:0] nx_pc;
  logic               nx_cp0;
  logic               nx_wb_en;
  logic [`REG_AW-1:0] nx_wb_addr;
  logic [`DATA_W-1:0] nx_wb_data;
  logic               nx_ex_wen;
  logic [`REG_AW-1:0] nx_ex_waddr;
  logic [`DATA_W-1:0] nx_ex_wdata;
  logic               nx_ex_is_load;
  logic               nx_mem_wen;
  logic [`REG_AW-1:0] nx_mem_waddr;
  logic [`DATA_W-1:0] nx_mem_wdata;
  logic [`DATA_W-1:0] held_inst;
  logic [`DATA_W-1:0] held_pc;
  logic               dec_now;
  logic               cap_prev;
  exp_t               last;
  exp_t               exp_q[$];
  int                 checked;

  initial clk = 1'b0;
  always #50 clk = ~clk;

  id_stage dut_i (
    .clk         (clk),
    .rst         (rst),
    .inst_valid  (inst_valid),
    .inst        (inst),
    .pc          (pc),
    .cp0_usable  (cp0_usable),
    .wb_en       (wb_en),
    .wb_addr     (wb_addr),
    .wb_data     (wb_data),
    .ex_wen      (ex_wen),
    .ex_waddr    (ex_waddr),
    .ex_wdata    (ex_wdata),
    .ex_is_load  (ex_is_load),
    .mem_wen     (mem_wen),
    .mem_waddr   (mem_waddr),
    .mem_wdata   (mem_wdata),
    .out_valid   (out_valid),
    .op1_data    (op1_data),
    .op1_pending (op1_pending),
    .op2_data    (op2_data),
    .op2_pending (op2_pending),
    .dst_en      (dst_en),
    .dst_addr    (dst_addr)
  );

  task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("tests failed");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  // mostly low registers so that forwards hit often
  function automatic logic [`REG_AW-1:0] rand_reg();
    logic [31:0] r;
    r = $random(seed);
    return r[5] ? r[4:0] : {2'b00, r[2:0]};
  endfunction

  function automatic logic [`DATA_W-1:0] fill_word(input logic [`REG_AW-1:0] a);
    return ({27'd0, a} * 32'h9e3779b9) ^ {a, a, a, a, a, a, 2'b10};
  endfunction

  task automatic set_idle();
    nx_inst_valid = 1'b0;
    nx_inst       = '0;
    nx_pc         = '0;
    nx_cp0        = 1'b0;
    nx_wb_en      = 1'b0;
    nx_wb_addr    = '0;
    nx_wb_data    = '0;
    nx_ex_wen     = 1'b0;
    nx_ex_waddr   = '0;
    nx_ex_wdata   = '0;
    nx_ex_is_load = 1'b0;
    nx_mem_wen    = 1'b0;
    nx_mem_waddr  = '0;
    nx_mem_wdata  = '0;
  endtask

  task automatic randomize_next();
    logic [31:0] r;
    logic [5:0]  op;
    logic [4:0]  rs;
    logic [4:0]  rt;
    r = $random(seed);
    nx_inst_valid = (r[1:0] != 2'b00);
    op = (r[6:2] < 5'd26) ? op_tbl[r[6:2]] : r[12:7];
    rs = rand_reg();
    rt = rand_reg();
    r = $random(seed);
    // steer rare fields toward the codes that matter
    if (op == `OP_REGIMM && r[31]) rt = {r[30], 3'b000, r[29]};
    if (op == `OP_CP0 && r[28]) rs = `CP0_MFC0;
    if (op == `OP_SPECIAL && r[27]) r[5:0] = `FUNCT_JALR;
    nx_inst = {op, rs, rt, r[15:0]};
    nx_pc   = $random(seed);
    r = $random(seed);
    nx_cp0        = r[0];
    nx_ex_wen     = r[1];
    nx_ex_is_load = r[2];
    nx_mem_wen    = r[3];
    nx_wb_en      = r[4];
    nx_ex_waddr   = rand_reg();
    nx_mem_waddr  = rand_reg();
    nx_wb_addr    = rand_reg();
    nx_ex_wdata   = $random(seed);
    nx_mem_wdata  = $random(seed);
    nx_wb_data    = $random(seed);
  endtask

  // outputs hold the last result while out_valid is low
  task automatic check_outputs();
    check_val({31'd0, out_valid}, {31'd0, cap_prev}, "out_valid");
    if (out_valid) begin
      last = exp_q.pop_front();
      checked++;
    end
    check_val(op1_data, last.op1, "op1_data");
    check_val({31'd0, op1_pending}, {31'd0, last.p1}, "op1_pending");
    check_val(op2_data, last.op2, "op2_data");
    check_val({31'd0, op2_pending}, {31'd0, last.p2}, "op2_pending");
    check_val({31'd0, dst_en}, {31'd0, last.den}, "dst_en");
    check_val({27'd0, dst_addr}, {27'd0, last.dad}, "dst_addr");
  endtask

  task automatic cycle();
    @(posedge clk);
    #1;
    check_outputs();
    if (wb_en && wb_addr != '0) begin
      shadow[wb_addr] = wb_data;
    end
    dec_now    = inst_valid;
    cp0_usable = nx_cp0;
    wb_en      = nx_wb_en;
    wb_addr    = nx_wb_addr;
    wb_data    = nx_wb_data;
    ex_wen     = nx_ex_wen;
    ex_waddr   = nx_ex_waddr;
    ex_wdata   = nx_ex_wdata;
    ex_is_load = nx_ex_is_load;
    mem_wen    = nx_mem_wen;
    mem_waddr  = nx_mem_waddr;
    mem_wdata  = nx_mem_wdata;
    // decode sees the side inputs of the cycle after capture
    if (dec_now) begin
      exp_q.push_back(decode_expect(held_inst, held_pc, cp0_usable));
    end
    inst_valid = nx_inst_valid;
    inst       = nx_inst;
    pc         = nx_pc;
    if (nx_inst_valid) begin
      held_inst = nx_inst;
      held_pc   = nx_pc;
    end
    cap_prev = dec_now;
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 || inst_valid) begin
      if (waited == DRAIN_LIMIT) begin
        $display("timeout: out_valid missing after %0d cycles", DRAIN_LIMIT);
        $display("tests failed");
        $fatal(1, "drain timeout");
      end
      cycle();
      waited++;
    end
  endtask

  initial begin
    seed   = 23;
    op_tbl = '{`OP_SPECIAL, `OP_REGIMM, `OP_J, `OP_JAL, `OP_BEQ, `OP_BNE, `OP_BLEZ,
               `OP_BGTZ, `OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU, `OP_ANDI, `OP_ORI,
               `OP_XORI, `OP_LUI, `OP_CP0, `OP_SPECIAL2, `OP_LB, `OP_LH, `OP_LW,
               `OP_LBU, `OP_LHU, `OP_SB, `OP_SH, `OP_SW};
    rst        = 1'b0;
    inst_valid = 1'b0;
    inst       = '0;
    pc         = '0;
    cp0_usable = 1'b0;
    wb_en      = 1'b0;
    wb_addr    = '0;
    wb_data    = '0;
    ex_wen     = 1'b0;
    ex_waddr   = '0;
    ex_wdata   = '0;
    ex_is_load = 1'b0;
    mem_wen    = 1'b0;
    mem_waddr  = '0;
    mem_wdata  = '0;
    held_inst  = '0;
    held_pc    = '0;
    dec_now    = 1'b0;
    cap_prev   = 1'b0;
    last       = '0;
    checked    = 0;
    set_idle();
    for (int i = 0; i < 8; i++) begin
      cycle();
    end
    rst = 1'b1;
    // array has no reset, load every register through wb first
    for (int a = 1; a < `NUM_REGS; a++) begin
      set_idle();
      nx_wb_en   = 1'b1;
      nx_wb_addr = a[4:0];
      nx_wb_data = fill_word(a[4:0]);
      cycle();
    end
    set_idle();
    cycle();
    for (int n = 0; n < N_INST; n++) begin
      randomize_next();
      cycle();
    end
    set_idle();
    drain();
    $display("checked %0d instructions", checked);
    $display("all tests passed");
    $finish;
  end

endmodule

//--- design/id_stage.sv
`timescale 1ns/1ps
`include "mips_consts.svh"

module id_stage (
  input  logic                clk,
  input  logic                rst,
  input  logic                inst_valid,
  input  logic [`DATA_W-1:0]  inst,
  input  logic [`DATA_W-1:0]  pc,
  input  logic                cp0_usable,
  input  logic                wb_en,
  input  logic [`REG_AW-1:0]  wb_addr,
  input  logic [`DATA_W-1:0]  wb_data,
  input  logic                ex_wen,
  input  logic [`REG_AW-1:0]  ex_waddr,
  input  logic [`DATA_W-1:0]  ex_wdata,
  input  logic                ex_is_load,
  input  logic                mem_wen,
  input  logic [`REG_AW-1:0]  mem_waddr,
  input  logic [`DATA_W-1:0]  mem_wdata,
  output logic                out_valid,
  output logic [`DATA_W-1:0]  op1_data,
  output logic                op1_pending,
  output logic [`DATA_W-1:0]  op2_data,
  output logic                op2_pending,
  output logic                dst_en,
  output logic [`REG_AW-1:0]  dst_addr
);

  isa_pkg::inst_u     inst_q;
  logic [`DATA_W-1:0] pc_q;
  logic               valid_q;
  pipe_pkg::operand_t op1;
  pipe_pkg::operand_t op2;
  logic               dst_en_d;
  isa_pkg::reg_addr_t dst_addr_d;
  logic               pend1;
  logic               pend2;
  pipe_pkg::fwd_src_t ex_src;
  pipe_pkg::fwd_src_t mem_src;

  regfile_if rq1_if ();
  regfile_if rq2_if ();
  regfile_if rf1_if ();
  regfile_if rf2_if ();

  assign ex_src  = '{wen: ex_wen, waddr: ex_waddr, wdata: ex_wdata, is_load: ex_is_load};
  // mem results are already loaded
  assign mem_src = '{wen: mem_wen, waddr: mem_waddr, wdata: mem_wdata, is_load: 1'b0};

  always_ff @(posedge clk) begin
    if (inst_valid) begin
      inst_q <= inst;
      pc_q   <= pc;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= inst_valid;
    end
  end

  reg_gen reg_gen_i (
    .inst       (inst_q),
    .pc         (pc_q),
    .cp0_usable (cp0_usable),
    .rd1        (rq1_if.reader),
    .rd2        (rq2_if.reader),
    .op1        (op1),
    .op2        (op2),
    .dst_en     (dst_en_d),
    .dst_addr   (dst_addr_d)
  );

  bypass_unit bypass1_i (
    .clk     (clk),
    .rst     (rst),
    .rq      (rq1_if.file),
    .rf      (rf1_if.reader),
    .ex      (ex_src),
    .mem     (mem_src),
    .pending (pend1)
  );

  bypass_unit bypass2_i (
    .clk     (clk),
    .rst     (rst),
    .rq      (rq2_if.file),
    .rf      (rf2_if.reader),
    .ex      (ex_src),
    .mem     (mem_src),
    .pending (pend2)
  );

  reg_file reg_file_i (
    .clk   (clk),
    .rd1   (rf1_if.file),
    .rd2   (rf2_if.file),
    .wen   (wb_en),
    .waddr (wb_addr),
    .wdata (wb_data)
  );

  // outputs hold between instructions
  always_ff @(posedge clk) begin
    if (!rst) begin
      out_valid   <= 1'b0;
      op1_data    <= '0;
      op1_pending <= 1'b0;
      op2_data    <= '0;
      op2_pending <= 1'b0;
      dst_en      <= 1'b0;
      dst_addr    <= '0;
    end else begin
      out_valid <= valid_q;
      if (valid_q) begin
        op1_data    <= op1.data;
        op1_pending <= op1.pending && pend1;
        op2_data    <= op2.data;
        op2_pending <= op2.pending && pend2;
        dst_en      <= dst_en_d;
        dst_addr    <= dst_addr_d;
      end
    end
  end

  a_out_valid: assert property (@(posedge clk) disable iff (!rst)
    $rose(out_valid) |-> $past(valid_q))
    else $error("out_valid without a decoded instruction");

endmodule

//--- design/reg_gen.sv
`timescale 1ns/1ps
`include "mips_consts.svh"

module reg_gen (
  input  isa_pkg::inst_u     inst,
  input  logic [`DATA_W-1:0] pc,
  input  logic               cp0_usable,
  regfile_if.reader          rd1,
  regfile_if.reader          rd2,
  output pipe_pkg::operand_t op1,
  output pipe_pkg::operand_t op2,
  output logic               dst_en,
  output isa_pkg::reg_addr_t dst_addr
);

  isa_pkg::opcode_t   op;
  logic [`DATA_W-1:0] imm_zext;
  logic [`DATA_W-1:0] imm_hi;
  logic [`DATA_W-1:0] imm_sext;
  logic [`DATA_W-1:0] link_addr;
  logic               regimm_known;
  logic               regimm_link;
  logic               jalr;
  logic               is_link;
  logic               imm_op2;

  assign op = inst.i.op;

  assign imm_zext = {{(`DATA_W - `IMM_W){1'b0}}, inst.i.imm};
  assign imm_hi   = {inst.i.imm, {(`DATA_W - `IMM_W){1'b0}}};
  assign imm_sext = {{(`DATA_W - `IMM_W){inst.i.imm[`IMM_W-1]}}, inst.i.imm};

  // return address skips the delay slot
  assign link_addr = pc + `LINK_OFFSET;

  assign regimm_link  = (inst.i.rt == `REGIMM_BLTZAL) || (inst.i.rt == `REGIMM_BGEZAL);
  assign regimm_known = regimm_link ||
                        (inst.i.rt == `REGIMM_BLTZ) || (inst.i.rt == `REGIMM_BGEZ);
  assign jalr         = (op == `OP_SPECIAL) && (inst.r.funct == `FUNCT_JALR);
  assign is_link      = (op == `OP_JAL) || jalr || ((op == `OP_REGIMM) && regimm_link);

  // read ports
  always_comb begin
    rd1.en   = 1'b0;
    rd1.addr = '0;
    rd2.en   = 1'b0;
    rd2.addr = '0;
    case (op)
      `OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU,
      `OP_ANDI, `OP_ORI, `OP_XORI,
      `OP_LB, `OP_LH, `OP_LW, `OP_LBU, `OP_LHU: begin
        rd1.en   = 1'b1;
        rd1.addr = inst.i.rs;
      end
      `OP_BEQ, `OP_BNE, `OP_BLEZ, `OP_BGTZ,
      `OP_SB, `OP_SH, `OP_SW,
      `OP_SPECIAL, `OP_SPECIAL2: begin
        rd1.en   = 1'b1;
        rd1.addr = inst.r.rs;
        rd2.en   = 1'b1;
        rd2.addr = inst.r.rt;
      end
      `OP_REGIMM: begin
        if (regimm_known) begin
          rd1.en   = 1'b1;
          rd1.addr = inst.i.rs;
        end
      end
      `OP_CP0: begin
        rd1.en   = 1'b1;
        rd1.addr = inst.i.rt;
      end
      default: begin
      end
    endcase
  end

  // pending here marks a register-sourced operand
  always_comb begin
    if (is_link) begin
      op1.data    = link_addr;
      op1.pending = 1'b0;
    end else if (rd1.en) begin
      op1.data    = rd1.data;
      op1.pending = 1'b1;
    end else begin
      op1.data    = '0;
      op1.pending = 1'b0;
    end
  end

  always_comb begin
    imm_op2 = 1'b1;
    case (op)
      `OP_ANDI, `OP_ORI, `OP_XORI: begin
        op2.data = imm_zext;
      end
      `OP_LUI: begin
        op2.data = imm_hi;
      end
      `OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU,
      `OP_LB, `OP_LH, `OP_LW, `OP_LBU, `OP_LHU,
      `OP_SB, `OP_SH, `OP_SW: begin
        op2.data = imm_sext;
      end
      default: begin
        imm_op2  = 1'b0;
        op2.data = rd2.en ? rd2.data : '0;
      end
    endcase
    op2.pending = !imm_op2 && rd2.en;
  end

  // write-back destination
  always_comb begin
    dst_en   = 1'b0;
    dst_addr = '0;
    case (op)
      `OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU,
      `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI,
      `OP_LB, `OP_LH, `OP_LW, `OP_LBU, `OP_LHU: begin
        dst_en   = 1'b1;
        dst_addr = inst.i.rt;
      end
      `OP_SPECIAL, `OP_SPECIAL2: begin
        dst_en   = 1'b1;
        dst_addr = inst.r.rd;
      end
      `OP_JAL: begin
        dst_en   = 1'b1;
        dst_addr = `LINK_REG;
      end
      `OP_REGIMM: begin
        if (regimm_link) begin
          dst_en   = 1'b1;
          dst_addr = `LINK_REG;
        end
      end
      `OP_CP0: begin
        // mfc0 only with the coprocessor enabled
        if (inst.i.rs == `CP0_MFC0 && cp0_usable) begin
          dst_en   = 1'b1;
          dst_addr = inst.i.rt;
        end
      end
      default: begin
      end
    endcase
  end

  always_comb begin
    if (dst_en && op == `OP_JAL) begin
      assert (dst_addr == `LINK_REG)
        else $error("jal destination is not the link register");
    end
    // a disabled port must not report a forward either
    if (imm_op2) begin
      assert (!op2.pending && (rd2.en || !rd2.fwd_hit))
        else $error("immediate operand marked as register sourced");
    end
  end

endmodule

//--- design/bypass_unit.sv
`timescale 1ns/1ps
`include "mips_consts.svh"

module bypass_unit (
  input  logic               clk,
  input  logic               rst,
  regfile_if.file            rq,
  regfile_if.reader          rf,
  input  pipe_pkg::fwd_src_t ex,
  input  pipe_pkg::fwd_src_t mem,
  output logic               pending
);

  logic ex_hit;
  logic mem_hit;

  // only a live read of a nonzero register can match
  function automatic logic src_match(input pipe_pkg::fwd_src_t src,
                                     input logic en,
                                     input isa_pkg::reg_addr_t addr);
    return en && src.wen && (src.waddr == addr) && (addr != '0);
  endfunction

  assign rf.en   = rq.en;
  assign rf.addr = rq.addr;

  assign ex_hit  = src_match(ex, rq.en, rq.addr);
  assign mem_hit = src_match(mem, rq.en, rq.addr);

  // youngest result first
  always_comb begin
    if (ex_hit) begin
      rq.data = ex.wdata;
    end else if (mem_hit) begin
      rq.data = mem.wdata;
    end else begin
      rq.data = rf.data;
    end
  end

  assign rq.fwd_hit = ex_hit || mem_hit || rf.fwd_hit;

  // load data not back yet
  assign pending = ex_hit && ex.is_load;

  a_pend_en: assert property (@(posedge clk) disable iff (!rst)
    pending |-> rq.en)
    else $error("pending without a read");

endmodule

//--- design/reg_file.sv
`timescale 1ns/1ps
`include "mips_consts.svh"

module reg_file (
  input  logic               clk,
  regfile_if.file            rd1,
  regfile_if.file            rd2,
  input  logic               wen,
  input  isa_pkg::reg_addr_t waddr,
  input  logic [`DATA_W-1:0] wdata
);

  logic [`DATA_W-1:0] regs [0:`NUM_REGS-1];
  logic               wr_live;

  // $zero is never written
  assign wr_live = wen && (waddr != '0);

  always_ff @(posedge clk) begin
    if (wr_live) begin
      regs[waddr] <= wdata;
    end
  end

  function automatic logic through_hit(input logic en, input isa_pkg::reg_addr_t addr);
    return en && wr_live && (waddr == addr);
  endfunction

  function automatic logic [`DATA_W-1:0] read_word(input logic en,
                                                   input isa_pkg::reg_addr_t addr);
    if (!en || addr == '0) begin
      return '0;
    end
    // same-cycle write wins over the stored value
    if (through_hit(en, addr)) begin
      return wdata;
    end
    return regs[addr];
  endfunction

  always_comb begin
    rd1.data    = read_word(rd1.en, rd1.addr);
    rd1.fwd_hit = through_hit(rd1.en, rd1.addr);
    rd2.data    = read_word(rd2.en, rd2.addr);
    rd2.fwd_hit = through_hit(rd2.en, rd2.addr);
  end

  // $zero holds zero on both ports, write-through included
  a_zero_reg: assert property (@(posedge clk)
    ((rd1.addr == '0) |-> (rd1.data == '0 && !rd1.fwd_hit)) and
    ((rd2.addr == '0) |-> (rd2.data == '0 && !rd2.fwd_hit)))
    else $error("register 0 read nonzero");

endmodule

//--- design/regfile_if.sv
`timescale 1ns/1ps
`include "mips_consts.svh"

interface regfile_if;

  logic               en;
  isa_pkg::reg_addr_t addr;
  logic [`DATA_W-1:0] data;
  // set when data did not come out of the register array
  logic               fwd_hit;

  modport reader (
    output en, addr,
    input  data, fwd_hit
  );

  modport file (
    input  en, addr,
    output data, fwd_hit
  );

endinterface

//--- design/pipe_pkg.sv
`include "mips_consts.svh"

package pipe_pkg;

  // operand handed to execute
  typedef struct packed {
    logic [`DATA_W-1:0] data;
    logic               pending;
  } operand_t;

  // result in flight from a later stage
  typedef struct packed {
    logic                 wen;
    isa_pkg::reg_addr_t   waddr;
    logic [`DATA_W-1:0]   wdata;
    logic                 is_load;
  } fwd_src_t;

endpackage

//--- design/isa_pkg.sv
`include "mips_consts.svh"

package isa_pkg;

  typedef logic [`REG_AW-1:0]  reg_addr_t;
  typedef logic [`OP_W-1:0]    opcode_t;
  typedef logic [`FUNCT_W-1:0] funct_t;
  typedef logic [`SHAMT_W-1:0] shamt_t;
  typedef logic [`IMM_W-1:0]   imm_t;

  // register format
  typedef struct packed {
    opcode_t   op;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    shamt_t    shamt;
    funct_t    funct;
  } r_fmt_t;

  // immediate format
  typedef struct packed {
    opcode_t   op;
    reg_addr_t rs;
    reg_addr_t rt;
    imm_t      imm;
  } i_fmt_t;

  // one instruction word, seen through either layout
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
  } inst_u;

endpackage

//--- design/mips_consts.svh
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// datapath widths
`define DATA_W        32
`define REG_AW        5
`define NUM_REGS      32
`define OP_W          6
`define FUNCT_W       6
`define SHAMT_W       5
`define IMM_W         16
`define FWD_CNT_W     16

// return address register and offset past the delay slot
`define LINK_REG      5'd31
`define LINK_OFFSET   32'd8

// primary opcodes
`define OP_SPECIAL    6'b000000
`define OP_REGIMM     6'b000001
`define OP_J          6'b000010
`define OP_JAL        6'b000011
`define OP_BEQ        6'b000100
`define OP_BNE        6'b000101
`define OP_BLEZ       6'b000110
`define OP_BGTZ       6'b000111
`define OP_ADDI       6'b001000
`define OP_ADDIU      6'b001001
`define OP_SLTI       6'b001010
`define OP_SLTIU      6'b001011
`define OP_ANDI       6'b001100
`define OP_ORI        6'b001101
`define OP_XORI       6'b001110
`define OP_LUI        6'b001111
`define OP_CP0        6'b010000
`define OP_SPECIAL2   6'b011100
`define OP_LB         6'b100000
`define OP_LH         6'b100001
`define OP_LW         6'b100011
`define OP_LBU        6'b100100
`define OP_LHU        6'b100101
`define OP_SB         6'b101000
`define OP_SH         6'b101001
`define OP_SW         6'b101011

// regimm rt codes
`define REGIMM_BLTZ   5'b00000
`define REGIMM_BGEZ   5'b00001
`define REGIMM_BLTZAL 5'b10000
`define REGIMM_BGEZAL 5'b10001

`define FUNCT_JALR    6'b001001
`define CP0_MFC0      5'b00000

`endif
